//--- Bender.yml
package:
  name: ucode_cpu

sources:
  - cpu_pkg.sv
  - ctrl_if.sv
  - microop_counter.sv
  - microcode_store.sv
  - control_logic.sv
  - alu_unit.sv
  - datapath.sv
  - cpu_top.sv
  - target: test
    files:
      - tb_cpu_top.sv

//--- alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit import cpu_pkg::*; (
  // TMP0 feeds a, TMP1 feeds b
  input  data_t                     a,
  input  data_t                     b,
  input  logic [UW_ALU_PLANE_W-1:0] alu_plane,
  output data_t                     mlu_y,
  output data_t                     shift_y
);

  mlu_op_e   mlu_op;
  shift_op_e shift_op;
  data_t     carry_in;

  assign mlu_op   = mlu_op_e'(alu_plane[2:0]);
  assign shift_op = shift_op_e'(alu_plane[1:0]);
  // Carry only matters for ADD and SUB
  assign carry_in = data_t'(alu_plane[3]);

  // MLU
  always_comb begin
    case (mlu_op)
      ADD:    mlu_y = a + b + carry_in;
      // Two's complement subtract needs carry-in set
      SUB:    mlu_y = a + ~b + carry_in;
      AND:    mlu_y = a & b;
      OR:     mlu_y = a | b;
      XOR:    mlu_y = a ^ b;
      PASS_A: mlu_y = a;
      NOT_A:  mlu_y = ~a;
      // Spare op code
      default: mlu_y = '0;
    endcase
  end

  // One-bit shifter on a
  always_comb begin
    case (shift_op)
      SHL: shift_y = {a[DATA_W-2:0], 1'b0};
      SHR: shift_y = {1'b0, a[DATA_W-1:1]};
      // Sign bit is copied down
      ASR: shift_y = {a[DATA_W-1], a[DATA_W-1:1]};
      // MSB wraps into bit 0
      ROL: shift_y = {a[DATA_W-2:0], a[DATA_W-1]};
      default: shift_y = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- control_logic.sv
`timescale 1ns/1ps
`default_nettype none

module control_logic import cpu_pkg::*; (
  input  wire     clk,
  input  wire     rst_n,
  // APB bootstrap port
  input  logic    psel,
  input  logic    penable,
  input  logic    pwrite,
  input  paddr_t  paddr,
  input  uword_t  pwdata,
  output uword_t  prdata,
  output logic    pready,
  output logic    pslverr,
  // Current opcode held in the datapath
  input  opcode_t opcode,
  output logic    booted,
  ctrl_if.ctrl    ctl
);

  step_t      step;
  uaddr_t     uaddr;
  uword_t     uword;
  in_plane_e  in_plane;
  out_plane_e out_plane;
  logic       end_step;

  microop_counter u_counter (
    .clk      (clk),
    .rst_n    (rst_n),
    .booted   (booted),
    .end_step (end_step),
    .count    (step)
  );

  // Each opcode owns a block of 16 micro-ops
  assign uaddr = {opcode, step};

  microcode_store u_store (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .uaddr   (uaddr),
    .uword   (uword),
    .booted  (booted)
  );

  // Field split of the current microcode word
  assign in_plane      = in_plane_e'(uword[UW_IN_PLANE_LSB +: UW_IN_PLANE_W]);
  assign out_plane     = out_plane_e'(uword[UW_OUT_PLANE_LSB +: UW_OUT_PLANE_W]);
  assign end_step      = uword[UW_END_STEP_BIT];
  assign ctl.alu_plane = uword[UW_ALU_PLANE_LSB +: UW_ALU_PLANE_W];
  assign ctl.reg_src   = uword[UW_REG_SRC_LSB +: UW_REG_SRC_W];
  assign ctl.reg_sel   = uword[UW_REG_SEL_LSB +: UW_REG_SEL_W];

  // In plane decoder, silent until booted
  always_comb begin
    ctl.ld_reg    = 1'b0;
    ctl.ld_tmp0   = 1'b0;
    ctl.ld_tmp1   = 1'b0;
    ctl.ld_opword = 1'b0;
    ctl.ld_opcode = 1'b0;
    ctl.ld_out    = 1'b0;
    if (booted) begin
      case (in_plane)
        IN_REG:     ctl.ld_reg    = 1'b1;
        IN_TMP0:    ctl.ld_tmp0   = 1'b1;
        IN_TMP1:    ctl.ld_tmp1   = 1'b1;
        IN_OPWORD:  ctl.ld_opword = 1'b1;
        IN_OPCODE:  ctl.ld_opcode = 1'b1;
        IN_EXT_OUT: ctl.ld_out    = 1'b1;
        // IN_NONE and the unused code load nothing
        default:    ;
      endcase
    end
  end

  // Out plane decoder, an undriven bus reads zero
  always_comb begin
    ctl.oe_reg   = 1'b0;
    ctl.oe_tmp0  = 1'b0;
    ctl.oe_tmp1  = 1'b0;
    ctl.oe_mlu   = 1'b0;
    ctl.oe_shift = 1'b0;
    ctl.oe_in    = 1'b0;
    if (booted) begin
      case (out_plane)
        OUT_REG:     ctl.oe_reg   = 1'b1;
        OUT_TMP0:    ctl.oe_tmp0  = 1'b1;
        OUT_TMP1:    ctl.oe_tmp1  = 1'b1;
        OUT_MLU:     ctl.oe_mlu   = 1'b1;
        OUT_SHIFTER: ctl.oe_shift = 1'b1;
        OUT_EXT_IN:  ctl.oe_in    = 1'b1;
        default:     ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // Datapath and sequencer widths
  localparam int DATA_W      = 8;
  localparam int OPCODE_W    = 4;
  localparam int STEP_W      = 4;
  localparam int UADDR_W     = OPCODE_W + STEP_W;
  localparam int UWORD_W     = 16;
  localparam int UCODE_DEPTH = 1 << UADDR_W;
  localparam int NUM_REGS    = 4;
  localparam int APB_ADDR_W  = 12;

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [OPCODE_W-1:0]   opcode_t;
  typedef logic [STEP_W-1:0]     step_t;
  // Opcode in the upper nibble, step in the lower one
  typedef logic [UADDR_W-1:0]    uaddr_t;
  typedef logic [UWORD_W-1:0]    uword_t;
  typedef logic [1:0]            reg_idx_t;
  typedef logic [APB_ADDR_W-1:0] paddr_t;

  // Microcode word layout, bit 15 is spare
  localparam int UW_REG_SRC_LSB   = 0;
  localparam int UW_REG_SRC_W     = 2;
  localparam int UW_REG_SEL_LSB   = 2;
  localparam int UW_REG_SEL_W     = 2;
  localparam int UW_ALU_PLANE_LSB = 4;
  localparam int UW_ALU_PLANE_W   = 4;
  localparam int UW_OUT_PLANE_LSB = 8;
  localparam int UW_OUT_PLANE_W   = 3;
  localparam int UW_IN_PLANE_LSB  = 11;
  localparam int UW_IN_PLANE_W    = 3;
  localparam int UW_END_STEP_BIT  = 14;

  // Bus destination, at most one per step
  typedef enum logic [2:0] {
    IN_NONE, IN_REG, IN_TMP0, IN_TMP1, IN_OPWORD, IN_OPCODE, IN_EXT_OUT
  } in_plane_e;

  // Bus source, at most one per step
  typedef enum logic [2:0] {
    OUT_NONE, OUT_REG, OUT_TMP0, OUT_TMP1, OUT_MLU, OUT_SHIFTER, OUT_EXT_IN
  } out_plane_e;

  // MLU op sits in alu_plane[2:0], alu_plane[3] is the carry-in
  typedef enum logic [2:0] {
    ADD, SUB, AND, OR, XOR, PASS_A, NOT_A
  } mlu_op_e;

  // Bit 0 picks left, bit 1 arithmetic; arithmetic left is a rotate
  typedef enum logic [1:0] {
    SHR = 2'b00,
    SHL = 2'b01,
    ASR = 2'b10,
    ROL = 2'b11
  } shift_op_e;

  // APB map, microcode words live below the boot register
  localparam paddr_t CTRL_ADDR = 12'h100;

endpackage

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
  input  wire    clk,
  input  wire    rst_n,
  // APB bootstrap
  input  logic   psel,
  input  logic   penable,
  input  logic   pwrite,
  input  paddr_t paddr,
  input  uword_t pwdata,
  output uword_t prdata,
  output logic   pready,
  output logic   pslverr,
  // Byte stream in and out
  input  data_t  in_data,
  output logic   in_take,
  output data_t  out_data,
  output logic   out_valid,
  output logic   booted
);

  opcode_t opcode;

  // Decoded controls from sequencer to datapath
  ctrl_if u_ctrl ();

  control_logic u_control (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .opcode  (opcode),
    .booted  (booted),
    .ctl     (u_ctrl.ctrl)
  );

  datapath u_datapath (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctl       (u_ctrl.dp),
    .in_data   (in_data),
    .in_take   (in_take),
    .out_data  (out_data),
    .out_valid (out_valid),
    .opcode    (opcode)
  );

endmodule

`default_nettype wire

//--- ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if import cpu_pkg::*; ();

  // One-hot destination loads
  logic ld_reg, ld_tmp0, ld_tmp1, ld_opword, ld_opcode, ld_out;
  // One-hot bus drivers
  logic oe_reg, oe_tmp0, oe_tmp1, oe_mlu, oe_shift, oe_in;
  // Raw microcode fields for the ALU and register selector
  logic [UW_ALU_PLANE_W-1:0] alu_plane;
  reg_idx_t                  reg_src;
  logic [UW_REG_SEL_W-1:0]   reg_sel;

  modport ctrl (
    output ld_reg, ld_tmp0, ld_tmp1, ld_opword, ld_opcode, ld_out,
    output oe_reg, oe_tmp0, oe_tmp1, oe_mlu, oe_shift, oe_in,
    output alu_plane, reg_src, reg_sel
  );

  modport dp (
    input ld_reg, ld_tmp0, ld_tmp1, ld_opword, ld_opcode, ld_out,
    input oe_reg, oe_tmp0, oe_tmp1, oe_mlu, oe_shift, oe_in,
    input alu_plane, reg_src, reg_sel
  );

endinterface

`default_nettype wire

//--- datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import cpu_pkg::*; (
  input  wire     clk,
  input  wire     rst_n,
  ctrl_if.dp      ctl,
  // Byte source, consumed on in_take
  input  data_t   in_data,
  output logic    in_take,
  // Byte sink, always ready
  output data_t   out_data,
  output logic    out_valid,
  output opcode_t opcode
);

  data_t    regs [NUM_REGS];
  data_t    tmp0;
  data_t    tmp1;
  data_t    opword;
  data_t    bus;
  data_t    mlu_y;
  data_t    shift_y;
  reg_idx_t reg_idx;

  alu_unit u_alu (
    .a         (tmp0),
    .b         (tmp1),
    .alu_plane (ctl.alu_plane),
    .mlu_y     (mlu_y),
    .shift_y   (shift_y)
  );

  // Register selector, 3 behaves like 2
  always_comb begin
    case (ctl.reg_sel)
      2'd0:    reg_idx = opword[1:0];
      2'd1:    reg_idx = opword[3:2];
      default: reg_idx = ctl.reg_src;
    endcase
  end

  // Bus mux, drivers are one-hot so OR-ing is enough
  always_comb begin
    bus = '0;
    if (ctl.oe_reg) begin
      bus = bus | regs[reg_idx];
    end
    if (ctl.oe_tmp0) begin
      bus = bus | tmp0;
    end
    if (ctl.oe_tmp1) begin
      bus = bus | tmp1;
    end
    if (ctl.oe_mlu) begin
      bus = bus | mlu_y;
    end
    if (ctl.oe_shift) begin
      bus = bus | shift_y;
    end
    if (ctl.oe_in) begin
      bus = bus | in_data;
    end
  end

  // Source advances after any edge with take high
  assign in_take = ctl.oe_in;

  // Destination registers load the bus at the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      tmp0   <= '0;
      tmp1   <= '0;
      opword <= '0;
      opcode <= '0;
    end else begin
      if (ctl.ld_reg) begin
        regs[reg_idx] <= bus;
      end
      if (ctl.ld_tmp0) begin
        tmp0 <= bus;
      end
      if (ctl.ld_tmp1) begin
        tmp1 <= bus;
      end
      if (ctl.ld_opword) begin
        opword <= bus;
      end
      // New opcode takes over from the next micro-op
      if (ctl.ld_opcode) begin
        opcode <= bus[OPCODE_W-1:0];
      end
    end
  end

  // Output stage, valid is a single-cycle pulse per output step
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= ctl.ld_out;
      if (ctl.ld_out) begin
        out_data <= bus;
      end
    end
  end

endmodule

`default_nettype wire

//--- files.f
cpu_pkg.sv
ctrl_if.sv
microop_counter.sv
microcode_store.sv
control_logic.sv
alu_unit.sv
datapath.sv
cpu_top.sv
tb_cpu_top.sv

//--- microcode_store.sv
`timescale 1ns/1ps
`default_nettype none

module microcode_store import cpu_pkg::*; (
  input  wire    clk,
  input  wire    rst_n,
  // APB slave
  input  logic   psel,
  input  logic   penable,
  input  logic   pwrite,
  input  paddr_t paddr,
  input  uword_t pwdata,
  output uword_t prdata,
  output logic   pready,
  output logic   pslverr,
  // Sequencer read port
  input  uaddr_t uaddr,
  output uword_t uword,
  output logic   booted
);

  uword_t mem [UCODE_DEPTH];

  logic access;
  logic in_ucode;
  logic at_ctrl;
  logic above_ctrl;
  logic bad_access;

  // Access phase of an APB transfer
  assign access     = psel && penable;
  assign in_ucode   = (paddr < CTRL_ADDR);
  assign at_ctrl    = (paddr == CTRL_ADDR);
  assign above_ctrl = (paddr > CTRL_ADDR);

  // Microcode is locked once booted, and boot cannot be cleared
  assign bad_access = above_ctrl
                   || (pwrite && in_ucode && booted)
                   || (pwrite && at_ctrl && !pwdata[0]);

  // Zero wait states
  assign pready  = 1'b1;
  assign pslverr = access && bad_access;

  // Readback of a word or the boot register
  always_comb begin
    prdata = '0;
    if (in_ucode) begin
      prdata = mem[paddr[UADDR_W-1:0]];
    end else if (at_ctrl) begin
      prdata[0] = booted;
    end
  end

  // Sequencer sees the word for the current step in the same cycle
  assign uword = mem[uaddr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < UCODE_DEPTH; i++) begin
        mem[i] <= '0;
      end
      booted <= 1'b0;
    end else if (access && pwrite && !bad_access) begin
      if (in_ucode) begin
        mem[paddr[UADDR_W-1:0]] <= pwdata;
      end else if (at_ctrl) begin
        // Only a 1 gets here, so boot is sticky
        booted <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- microop_counter.sv
`timescale 1ns/1ps
`default_nettype none

module microop_counter import cpu_pkg::*; (
  input  wire   clk,
  input  wire   rst_n,
  // Counting starts once the host has set the boot bit
  input  logic  booted,
  // Last micro-op of the current opcode
  input  logic  end_step,
  output step_t count
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (!booted) begin
      // Parked on step 0 while microcode is being loaded
      count <= '0;
    end else if (end_step) begin
      // Next opcode starts its micro-program from the top
      count <= '0;
    end else begin
      // Step 15 rolls over to 0 by itself
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

  // Test microcode uses opcode 0 for fetch and 1 to 7 for the MLU ops
  localparam opcode_t OP_SHIFT    = 4'd8;
  localparam opcode_t OP_STORE_LO = 4'd9;
  localparam opcode_t OP_LOAD_SEL = 4'd10;
  localparam opcode_t OP_LOAD_SRC = 4'd11;
  localparam opcode_t OP_STORE_HI = 4'd12;
  localparam int RAND_INSTR = 200;
  // Directed plus random instructions stay below this
  localparam int MAX_INSTR  = 240;
  localparam int APB_XFERS  = 2 * UCODE_DEPTH + 16;
  // Every instruction fits in 16 steps and every APB transfer in 3 cycles
  localparam int WATCHDOG_CYCLES = MAX_INSTR * 16 + APB_XFERS * 3 + 200;

  logic   clk;
  logic   rst_n;
  logic   psel;
  logic   penable;
  logic   pwrite;
  paddr_t paddr;
  uword_t pwdata;
  uword_t prdata;
  logic   pready;
  logic   pslverr;
  data_t  in_data;
  logic   in_take;
  data_t  out_data;
  logic   out_valid;
  logic   booted;

  uword_t ucode [UCODE_DEPTH];
  data_t  regs_m [NUM_REGS];
  data_t  in_q [$];
  data_t  exp_q [$];
  data_t  exp_b;
  data_t  dropped;
  logic   feed_en;
  logic   presenting;
  uword_t rdata_last;
  logic   err_last;
  int     mismatches;
  int     failures;
  int     outputs_seen;
  int     expected_total;
  int     seed_ret;

  cpu_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .in_data   (in_data),
    .in_take   (in_take),
    .out_data  (out_data),
    .out_valid (out_valid),
    .booted    (booted)
  );

  always #4 clk = ~clk;

  // Byte source presents the next byte after an edge that took one
  always @(posedge clk) begin
    if (feed_en) begin
      if (in_take && presenting) begin
        dropped = in_q.pop_front();
      end
      if (in_q.size() > 0) begin
        in_data    <= in_q[0];
        presenting <= 1'b1;
      end else begin
        // Idle source reads as opcode 0, so the CPU keeps fetching
        in_data    <= '0;
        presenting <= 1'b0;
      end
    end
  end

  // Output checker
  always @(posedge clk) begin
    if (rst_n) begin
      assert (booted || (!in_take && !out_valid)) else begin
        failures++;
        $display("Byte port active before boot at %0t", $time);
      end
      if (out_valid) begin
        outputs_seen++;
        assert (exp_q.size() > 0) else begin
          failures++;
          $display("Unexpected output byte %02h at %0t", out_data, $time);
        end
        if (exp_q.size() > 0) begin
          exp_b = exp_q.pop_front();
          assert (out_data == exp_b) else begin
            mismatches++;
            $display("MISMATCH at %0t: out_data got %02h expected %02h",
                     $time, out_data, exp_b);
          end
        end
      end
    end
  end

  task automatic check_true(input logic ok, input string what);
    assert (ok) else begin
      failures++;
      $display("Check failed at %0t: %s", $time, what);
    end
  endtask

  task automatic expect_rdata(input uword_t want, input paddr_t addr);
    assert (rdata_last == want) else begin
      mismatches++;
      $display("MISMATCH at %0t: prdata[%03h] got %04h expected %04h",
               $time, addr, rdata_last, want);
    end
  endtask

  // One APB transfer with a setup and an access cycle
  task automatic apb_xfer(input logic wr, input paddr_t addr, input uword_t data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    // pready is tied high, so the access ends at this edge
    @(posedge clk);
    rdata_last = prdata;
    err_last   = pslverr;
    check_true(pready, "pready low in access cycle");
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  function automatic uword_t uw(in_plane_e dst, out_plane_e src, logic [3:0] alu,
                                logic [1:0] sel, logic [1:0] ridx, logic last);
    uword_t w;
    w = '0;
    w[UW_IN_PLANE_LSB +: UW_IN_PLANE_W]   = dst;
    w[UW_OUT_PLANE_LSB +: UW_OUT_PLANE_W] = src;
    w[UW_ALU_PLANE_LSB +: UW_ALU_PLANE_W] = alu;
    w[UW_REG_SEL_LSB +: UW_REG_SEL_W]     = sel;
    w[UW_REG_SRC_LSB +: UW_REG_SRC_W]     = ridx;
    w[UW_END_STEP_BIT]                    = last;
    return w;
  endfunction

  function automatic void put(opcode_t op, step_t s, uword_t w);
    ucode[{op, s}] = w;
  endfunction

  task automatic build_ucode();
    uword_t     ret;
    logic [2:0] code;
    // Return step loads opcode 0 from the undriven bus
    ret = uw(IN_OPCODE, OUT_NONE, 4'h0, 2'd0, 2'd0, 1'b1);
    for (int i = 0; i < UCODE_DEPTH; i++) begin
      ucode[i] = '0;
    end
    put(4'd0, 4'd0, uw(IN_OPCODE, OUT_EXT_IN, 4'h0, 2'd0, 2'd0, 1'b1));
    for (int m = 0; m < 7; m++) begin
      code = m[2:0];
      put(opcode_t'(m + 1), 4'd0, uw(IN_TMP0, OUT_EXT_IN, 4'h0, 2'd0, 2'd0, 1'b0));
      put(opcode_t'(m + 1), 4'd1, uw(IN_TMP1, OUT_EXT_IN, 4'h0, 2'd0, 2'd0, 1'b0));
      put(opcode_t'(m + 1), 4'd2, uw(IN_EXT_OUT, OUT_MLU, {1'b0, code}, 2'd0, 2'd0, 1'b0));
      put(opcode_t'(m + 1), 4'd3, uw(IN_EXT_OUT, OUT_MLU, {1'b1, code}, 2'd0, 2'd0, 1'b0));
      put(opcode_t'(m + 1), 4'd4, ret);
    end
    put(OP_SHIFT, 4'd0, uw(IN_TMP0, OUT_EXT_IN, 4'h0, 2'd0, 2'd0, 1'b0));
    put(OP_SHIFT, 4'd1, uw(IN_EXT_OUT, OUT_SHIFTER, {2'b00, SHR}, 2'd0, 2'd0, 1'b0));
    put(OP_SHIFT, 4'd2, uw(IN_EXT_OUT, OUT_SHIFTER, {2'b00, SHL}, 2'd0, 2'd0, 1'b0));
    put(OP_SHIFT, 4'd3, uw(IN_EXT_OUT, OUT_SHIFTER, {2'b00, ASR}, 2'd0, 2'd0, 1'b0));
    put(OP_SHIFT, 4'd4, uw(IN_EXT_OUT, OUT_SHIFTER, {2'b00, ROL}, 2'd0, 2'd0, 1'b0));
    put(OP_SHIFT, 4'd5, ret);
    // Stores through either OPWORD field
    put(OP_STORE_LO, 4'd0, uw(IN_OPWORD, OUT_EXT_IN, 4'h0, 2'd0, 2'd0, 1'b0));
    put(OP_STORE_LO, 4'd1, uw(IN_REG, OUT_EXT_IN, 4'h0, 2'd0, 2'd0, 1'b0));
    put(OP_STORE_LO, 4'd2, ret);
    put(OP_STORE_HI, 4'd0, uw(IN_OPWORD, OUT_EXT_IN, 4'h0, 2'd0, 2'd0, 1'b0));
    put(OP_STORE_HI, 4'd1, uw(IN_REG, OUT_EXT_IN, 4'h0, 2'd1, 2'd0, 1'b0));
    put(OP_STORE_HI, 4'd2, ret);
    put(OP_LOAD_SEL, 4'd0, uw(IN_OPWORD, OUT_EXT_IN, 4'h0, 2'd0, 2'd0, 1'b0));
    put(OP_LOAD_SEL, 4'd1, uw(IN_EXT_OUT, OUT_REG, 4'h0, 2'd0, 2'd0, 1'b0));
    put(OP_LOAD_SEL, 4'd2, uw(IN_EXT_OUT, OUT_REG, 4'h0, 2'd1, 2'd0, 1'b0));
    put(OP_LOAD_SEL, 4'd3, ret);
    // All four registers by microcode index and then selector 3 on index 1
    for (int k = 0; k < NUM_REGS; k++) begin
      put(OP_LOAD_SRC, step_t'(k), uw(IN_EXT_OUT, OUT_REG, 4'h0, 2'd2, k[1:0], 1'b0));
    end
    put(OP_LOAD_SRC, 4'd4, uw(IN_EXT_OUT, OUT_REG, 4'h0, 2'd3, 2'd1, 1'b0));
    put(OP_LOAD_SRC, 4'd5, ret);
  endtask

  function automatic data_t mlu_model(mlu_op_e op, logic cin, data_t a, data_t b);
    int r;
    case (op)
      ADD:     r = a + b + cin;
      SUB:     r = a - b - 1 + cin;
      AND:     r = a & b;
      OR:      r = a | b;
      XOR:     r = a ^ b;
      PASS_A:  r = a;
      NOT_A:   r = 255 - a;
      default: r = 0;
    endcase
    return data_t'(r);
  endfunction

  function automatic data_t shift_model(shift_op_e op, data_t a);
    int r;
    case (op)
      SHR:     r = a / 2;
      SHL:     r = a * 2;
      ASR:     r = a / 2 + (a & 8'h80);
      ROL:     r = a * 2 + a / 128;
      default: r = 0;
    endcase
    return data_t'(r);
  endfunction

  task automatic push_exp(input data_t v);
    exp_q.push_back(v);
    expected_total++;
  endtask

  // Opcode byte with a random upper nibble the CPU ignores
  task automatic push_op(input opcode_t op);
    logic [3:0] junk;
    junk = $urandom_range(15, 0);
    in_q.push_back({junk, op});
  endtask

  task automatic mlu_instr(input int m, input data_t a, input data_t b);
    push_op(opcode_t'(m + 1));
    in_q.push_back(a);
    in_q.push_back(b);
    push_exp(mlu_model(mlu_op_e'(m), 1'b0, a, b));
    push_exp(mlu_model(mlu_op_e'(m), 1'b1, a, b));
  endtask

  task automatic shift_instr(input data_t a);
    push_op(OP_SHIFT);
    in_q.push_back(a);
    push_exp(shift_model(SHR, a));
    push_exp(shift_model(SHL, a));
    push_exp(shift_model(ASR, a));
    push_exp(shift_model(ROL, a));
  endtask

  task automatic store_instr(input logic hi, input data_t ow, input data_t v);
    push_op(hi ? OP_STORE_HI : OP_STORE_LO);
    in_q.push_back(ow);
    in_q.push_back(v);
    regs_m[hi ? ow[3:2] : ow[1:0]] = v;
  endtask

  task automatic load_sel_instr(input data_t ow);
    push_op(OP_LOAD_SEL);
    in_q.push_back(ow);
    push_exp(regs_m[ow[1:0]]);
    push_exp(regs_m[ow[3:2]]);
  endtask

  task automatic load_src_instr();
    push_op(OP_LOAD_SRC);
    for (int k = 0; k < NUM_REGS; k++) begin
      push_exp(regs_m[k]);
    end
    push_exp(regs_m[1]);
  endtask

  task automatic drain();
    while (exp_q.size() > 0 || in_q.size() > 0) begin
      @(posedge clk);
    end
    // Let the return step and a fetch go by
    repeat (4) @(posedge clk);
  endtask

  initial begin
    seed_ret = $urandom(93927);
    clk = 1'b0;
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    in_data = '0;
    feed_en = 1'b0;
    presenting = 1'b0;
    mismatches = 0;
    failures = 0;
    outputs_seen = 0;
    expected_total = 0;
    for (int k = 0; k < NUM_REGS; k++) begin
      regs_m[k] = '0;
    end
    build_ucode();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_true(!out_valid && !in_take && !pslverr && !booted, "outputs not idle after reset");

    for (int i = 0; i < UCODE_DEPTH; i++) begin
      apb_xfer(1'b1, paddr_t'(i), ucode[i]);
      check_true(!err_last, "microcode write before boot flagged an error");
    end

    // Fetch word is loaded but not booted while a byte waits at the input
    in_data <= 8'hA5;
    repeat (20) @(posedge clk);
    in_data <= '0;
    feed_en <= 1'b1;

    apb_xfer(1'b1, CTRL_ADDR, 16'h0000);
    check_true(err_last, "writing 0 to the boot bit gave no error");
    apb_xfer(1'b1, CTRL_ADDR, 16'h0001);
    check_true(!err_last, "boot write flagged an error");
    apb_xfer(1'b0, CTRL_ADDR, '0);
    expect_rdata(16'h0001, CTRL_ADDR);
    check_true(booted, "booted output low after the boot write");
    for (int i = 0; i < UCODE_DEPTH; i++) begin
      apb_xfer(1'b0, paddr_t'(i), '0);
      check_true(!err_last, "microcode read flagged an error");
      expect_rdata(ucode[i], paddr_t'(i));
    end
    // Store is locked once booted
    apb_xfer(1'b1, 12'h012, 16'hFFFF);
    check_true(err_last, "microcode write after boot gave no error");
    apb_xfer(1'b0, 12'h012, '0);
    expect_rdata(ucode[8'h12], 12'h012);
    apb_xfer(1'b1, 12'h101, 16'h0001);
    check_true(err_last, "write above the boot register gave no error");
    apb_xfer(1'b0, 12'hFFF, '0);
    check_true(err_last, "read above the boot register gave no error");
    apb_xfer(1'b1, CTRL_ADDR, 16'h0000);
    check_true(err_last && booted, "boot bit could be cleared");

    // MLU ops with both carries and the carry edge cases
    @(negedge clk);
    for (int m = 0; m < 7; m++) begin
      mlu_instr(m, data_t'($urandom_range(255, 0)), data_t'($urandom_range(255, 0)));
    end
    mlu_instr(0, 8'hFF, 8'h01);
    mlu_instr(1, 8'h00, 8'h01);
    drain();

    // Shifter sign fill and rotate wrap
    @(negedge clk);
    shift_instr(8'h81);
    shift_instr(8'h40);
    shift_instr(data_t'($urandom_range(255, 0)));
    shift_instr(data_t'($urandom_range(255, 0)));
    drain();

    // Register file under both selectors and the microcode index
    @(negedge clk);
    store_instr(1'b0, 8'h02, 8'h3C);
    store_instr(1'b1, 8'h0C, 8'hC3);
    store_instr(1'b0, 8'h00, data_t'($urandom_range(255, 0)));
    store_instr(1'b1, 8'h04, data_t'($urandom_range(255, 0)));
    load_sel_instr(8'h0E);
    load_sel_instr(8'h04);
    load_src_instr();
    drain();

    @(negedge clk);
    for (int n = 0; n < RAND_INSTR; n++) begin
      case ($urandom_range(4, 0))
        0: mlu_instr($urandom_range(6, 0), data_t'($urandom_range(255, 0)),
                     data_t'($urandom_range(255, 0)));
        1: shift_instr(data_t'($urandom_range(255, 0)));
        2: store_instr($urandom_range(1, 0), data_t'($urandom_range(255, 0)),
                       data_t'($urandom_range(255, 0)));
        3: load_sel_instr(data_t'($urandom_range(255, 0)));
        default: load_src_instr();
      endcase
    end
    drain();

    repeat (20) @(posedge clk);
    // A stretched out_valid shows up as extra pulses
    check_true(outputs_seen == expected_total, "output pulse count differs from output steps");
    $display("Errors: %0d mismatches, %0d other failures, %0d of %0d output bytes seen",
             mismatches, failures, outputs_seen, expected_total);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
